//--- rtl/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // address split: | tag 20 | index 6 | offset 6 |
    localparam int ADDR_W     = 32;
    localparam int INDEX_W    = 6;
    localparam int OFFSET_W   = 6;
    localparam int TAG_W      = ADDR_W - INDEX_W - OFFSET_W;

    // line and memory beat sizes
    localparam int LINE_W     = 512;
    localparam int BEAT_W     = 128;
    localparam int LINE_BEATS = LINE_W / BEAT_W;

    typedef logic [ADDR_W-1:0]  addr_t;     // fetch pc, also used as physical address
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic [BEAT_W-1:0]  beat_t;
    typedef logic [63:0]        fetch_t;    // two instructions
    typedef logic [7:0]         cookie_t;

    // cache operation codes
    // codes 0 and 1 both invalidate by index, addr bit 0 picks the way
    typedef enum logic [1:0] {
        CACOP_IDX0 = 2'd0,
        CACOP_IDX1 = 2'd1,
        CACOP_HIT  = 2'd2   // invalidate the way that hits
    } cacop_t;

endpackage

`default_nettype wire

//--- rtl/icache_data_ram.sv
`default_nettype none

module icache_data_ram (
    input  wire                      clk,
    input  wire icache_pkg::index_t  i_rd_index,
    input  wire icache_pkg::index_t  i_wr_index,
    input  wire                      i_we,
    input  wire icache_pkg::line_t   i_wdata,
    output icache_pkg::line_t        o_rdata
);

    import icache_pkg::*;

    line_t mem [0:(1 << INDEX_W) - 1];  // one line per set

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_wr_index] <= i_wdata;
        end
        // same index as a write gives the old line
        o_rdata <= mem[i_rd_index];
    end

endmodule

`default_nettype wire

//--- rtl/icache_tagv_ram.sv
`default_nettype none

module icache_tagv_ram (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire icache_pkg::index_t  i_rd_index,
    input  wire icache_pkg::index_t  i_wr_index,
    input  wire                      i_we,
    input  wire icache_pkg::tag_t    i_wtag,
    input  wire                      i_inval,
    input  wire                      i_clr_all,
    output icache_pkg::tag_t         o_tag,
    output logic                     o_valid
);

    import icache_pkg::*;

    tag_t                   tags [0:(1 << INDEX_W) - 1];
    logic [(1 << INDEX_W)-1:0] valid;   // kept in flops so ibar can wipe them at once

    always_ff @(posedge clk) begin
        if (i_we) begin
            tags[i_wr_index] <= i_wtag;
        end
        o_tag <= tags[i_rd_index];
    end

    always_ff @(posedge clk) begin
        if (!rstn || i_clr_all) begin
            valid <= '0;
        end else if (i_we) begin
            valid[i_wr_index] <= !i_inval;  // invalidate clears, refill sets
        end
    end

    // a read on the barrier edge already sees the cleared bit
    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= valid[i_rd_index] && !i_clr_all;
        end
    end

    // controller holds off writes while a barrier is in flight
    a_no_we_on_clr: assert property (@(posedge clk) disable iff (!rstn)
        !(i_we && i_clr_all));

endmodule

`default_nettype wire

//--- rtl/icache_refill.sv
`default_nettype none

module icache_refill (
    input  wire                      clk,
    input  wire                      rstn,
    input  wire                      i_miss_start,
    input  wire icache_pkg::addr_t   i_miss_addr,
    input  wire                      i_miss_uncache,
    input  wire                      i_mem_gnt,
    input  wire                      i_mem_valid,
    input  wire icache_pkg::beat_t   i_mem_data,
    input  wire                      i_mem_last,
    output logic                     o_mem_req,
    output icache_pkg::addr_t        o_mem_addr,
    output logic [2:0]               o_mem_beats,
    output logic                     o_line_done,
    output icache_pkg::line_t        o_fill_line
);

    import icache_pkg::*;

    logic                          xfer;        // granted, beats still coming
    logic [$clog2(LINE_BEATS)-1:0] beat_cnt;
    line_t                         line_buf;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            o_mem_req   <= 1'b0;
            xfer        <= 1'b0;
            beat_cnt    <= '0;
            o_line_done <= 1'b0;
        end else begin
            o_line_done <= 1'b0;
            if (i_miss_start) begin
                o_mem_req <= 1'b1;
                beat_cnt  <= '0;
            end else if (o_mem_req && i_mem_gnt) begin
                o_mem_req <= 1'b0;
                xfer      <= 1'b1;
            end
            if (xfer && i_mem_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (i_mem_last) begin
                    xfer        <= 1'b0;
                    o_line_done <= 1'b1;   // line buffer complete next cycle
                end
            end
        end
    end

    // request fields, held until the grant
    always_ff @(posedge clk) begin
        if (i_miss_start) begin
            if (i_miss_uncache) begin
                o_mem_addr  <= {i_miss_addr[ADDR_W-1:3], 3'b000};  // one 8-byte word
                o_mem_beats <= 3'd1;
            end else begin
                o_mem_addr  <= {i_miss_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
                o_mem_beats <= 3'(LINE_BEATS);
            end
        end
    end

    // beat k lands at line bytes 16k..16k+15
    always_ff @(posedge clk) begin
        if (xfer && i_mem_valid) begin
            line_buf[beat_cnt * BEAT_W +: BEAT_W] <= i_mem_data;
        end
    end

    assign o_fill_line = line_buf;

    a_beat_in_xfer: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_valid |-> xfer);

endmodule

`default_nettype wire

//--- rtl/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
    input  wire                       clk,
    input  wire                       rstn,
    // pipeline side
    input  wire                       i_rvalid,
    input  wire icache_pkg::addr_t    i_raddr,
    input  wire                       i_uncache,
    input  wire icache_pkg::cookie_t  i_cookie,
    input  wire                       i_flush,
    input  wire                       i_cacop_en,
    input  wire icache_pkg::cacop_t   i_cacop_code,
    input  wire                       i_ibar,
    output logic                      o_rready,
    output icache_pkg::fetch_t        o_rdata,
    output icache_pkg::addr_t         o_pc,
    output icache_pkg::cookie_t       o_cookie,
    output logic                      o_exc,
    output icache_pkg::addr_t         o_badv,
    output logic                      o_idle,
    output logic                      o_cacop_ready,
    output logic                      o_cacop_done,
    // arrays
    output icache_pkg::index_t        o_rd_index,
    output icache_pkg::index_t        o_wr_index,
    output logic [1:0]                o_data_we,
    output logic [1:0]                o_tag_we,
    output icache_pkg::tag_t          o_tag_wdata,
    output logic                      o_tag_inval,
    input  wire icache_pkg::tag_t     i_tag0,
    input  wire                       i_valid0,
    input  wire icache_pkg::tag_t     i_tag1,
    input  wire                       i_valid1,
    input  wire icache_pkg::line_t    i_data0,
    input  wire icache_pkg::line_t    i_data1,
    // refill unit
    output logic                      o_miss_start,
    output icache_pkg::addr_t         o_miss_addr,
    output logic                      o_miss_uncache,
    input  wire                       i_line_done,
    input  wire icache_pkg::line_t    i_fill_line
);

    import icache_pkg::*;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS,
        S_REFILL,
        S_CACOP
    } state_t;

    state_t state, state_nxt;

    // request buffer
    addr_t   pc_buf;        // also holds the cacop operand
    logic    unc_buf;
    cookie_t cookie_buf;
    cacop_t  cacop_buf;
    logic    live;          // cleared by flush, squashes the response
    logic    miss_busy;

    logic [(1 << INDEX_W)-1:0] lru;    // way to replace next, per set

    index_t  pc_index;
    tag_t    pc_tag;
    logic    hit0;
    logic    hit1;
    logic    misalign;
    logic    need_miss;
    logic    resp;
    logic    take;
    logic    cacop_take;
    logic    victim;
    logic    fill_we;
    logic [1:0] cacop_ways;
    line_t   line_sel;
    fetch_t  word;

    assign pc_index = pc_buf[OFFSET_W +: INDEX_W];
    assign pc_tag   = pc_buf[ADDR_W-1 -: TAG_W];
    assign misalign = |pc_buf[1:0];     // ADEF

    // tag compare on the registered array outputs
    assign hit0 = i_valid0 && (i_tag0 == pc_tag);
    assign hit1 = i_valid1 && (i_tag1 == pc_tag);

    assign need_miss = !misalign && (unc_buf || !(hit0 || hit1));
    assign resp      = (state == S_LOOKUP && !need_miss) || state == S_REFILL;

    // handshake
    assign o_idle        = state == S_IDLE;
    assign o_rready      = resp && live && !i_flush;
    assign take          = i_rvalid && (o_idle || o_rready);
    assign o_cacop_ready = o_idle && !i_rvalid;     // fetches win over cacops
    assign cacop_take    = i_cacop_en && o_cacop_ready;
    assign o_cacop_done  = state == S_CACOP;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (cacop_take) begin
                    state_nxt = S_CACOP;
                end else if (take) begin
                    state_nxt = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (o_miss_start) begin
                    state_nxt = S_MISS;
                end else if (take) begin
                    state_nxt = S_LOOKUP;
                end else begin
                    state_nxt = S_IDLE;
                end
            end
            S_MISS: begin
                if (i_line_done) begin
                    state_nxt = S_REFILL;
                end
            end
            S_REFILL: state_nxt = take ? S_LOOKUP : S_IDLE;
            S_CACOP:  state_nxt = S_IDLE;
            default:  state_nxt = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (take || cacop_take) begin
            pc_buf <= i_raddr;
        end
        if (take) begin
            unc_buf    <= i_uncache;
            cookie_buf <= i_cookie;
        end
        if (cacop_take) begin
            cacop_buf <= i_cacop_code;
        end
    end

    // a request taken on the flush edge is a new one and stays live
    always_ff @(posedge clk) begin
        if (!rstn) begin
            live <= 1'b0;
        end else if (take) begin
            live <= 1'b1;
        end else if (i_flush) begin
            live <= 1'b0;
        end
    end

    // miss goes out only for a live request; a flushed one just drops
    assign o_miss_start   = state == S_LOOKUP && need_miss && live && !i_flush;
    assign o_miss_addr    = pc_buf;
    assign o_miss_uncache = unc_buf;

    // fill at the line_done edge so a request taken in REFILL already hits
    assign victim  = lru[pc_index];
    assign fill_we = state == S_MISS && i_line_done && !unc_buf && !i_ibar;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (fill_we) begin
            lru[pc_index] <= !victim;
        end else if (state == S_LOOKUP && !misalign && !unc_buf && (hit0 || hit1)) begin
            lru[pc_index] <= hit0;      // other way becomes the victim
        end
    end

    assign cacop_ways = (cacop_buf == CACOP_HIT) ? {hit1, hit0} : {pc_buf[0], !pc_buf[0]};

    assign o_rd_index  = i_raddr[OFFSET_W +: INDEX_W];
    assign o_wr_index  = pc_index;
    assign o_data_we   = fill_we ? {victim, !victim} : 2'b00;
    assign o_tag_we    = i_ibar ? 2'b00 : (state == S_CACOP) ? cacop_ways : o_data_we;
    assign o_tag_wdata = pc_tag;
    assign o_tag_inval = state == S_CACOP;

    // fetch word select, bits 5:3
    assign line_sel = (state == S_REFILL) ? i_fill_line : (hit1 ? i_data1 : i_data0);
    assign word     = line_sel[pc_buf[OFFSET_W-1:3] * $bits(fetch_t) +: $bits(fetch_t)];
    assign o_rdata  = (state == S_REFILL && unc_buf) ? i_fill_line[63:0] : word;

    assign o_pc     = pc_buf;
    assign o_cookie = cookie_buf;
    assign o_exc    = misalign;
    assign o_badv   = misalign ? pc_buf : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            miss_busy <= 1'b0;
        end else if (o_miss_start) begin
            miss_busy <= 1'b1;
        end else if (i_line_done) begin
            miss_busy <= 1'b0;
        end
    end

    a_no_resp_in_miss: assert property (@(posedge clk) disable iff (!rstn)
        !(o_rready && miss_busy));

    // refill only on a miss, so a tag never lives in both ways
    a_one_hit_way: assert property (@(posedge clk) disable iff (!rstn)
        (state == S_LOOKUP || state == S_CACOP) |-> !(hit0 && hit1));

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`default_nettype none

module icache_top (
    input  wire                       clk,
    input  wire                       rstn,
    input  wire                       i_rvalid,
    input  wire icache_pkg::addr_t    i_raddr,
    input  wire                       i_uncache,
    input  wire icache_pkg::cookie_t  i_cookie,
    input  wire                       i_flush,
    input  wire                       i_cacop_en,
    input  wire icache_pkg::cacop_t   i_cacop_code,
    input  wire                       i_ibar,
    input  wire                       i_mem_gnt,
    input  wire                       i_mem_valid,
    input  wire icache_pkg::beat_t    i_mem_data,
    input  wire                       i_mem_last,
    output logic                      o_rready,
    output icache_pkg::fetch_t        o_rdata,
    output icache_pkg::addr_t         o_pc,
    output icache_pkg::cookie_t       o_cookie,
    output logic                      o_exc,
    output icache_pkg::addr_t         o_badv,
    output logic                      o_idle,
    output logic                      o_cacop_ready,
    output logic                      o_cacop_done,
    output logic                      o_mem_req,
    output icache_pkg::addr_t         o_mem_addr,
    output logic [2:0]                o_mem_beats
);

    import icache_pkg::*;

    index_t     rd_index;
    index_t     wr_index;
    logic [1:0] data_we;
    logic [1:0] tag_we;
    tag_t       tag_wdata;
    logic       tag_inval;
    tag_t       tag0;
    tag_t       tag1;
    logic       valid0;
    logic       valid1;
    line_t      data0;
    line_t      data1;
    logic       miss_start;
    addr_t      miss_addr;
    logic       miss_uncache;
    logic       line_done;
    line_t      fill_line;

    icache_ctrl u_ctrl (
        .clk            (clk),
        .rstn           (rstn),
        .i_rvalid       (i_rvalid),
        .i_raddr        (i_raddr),
        .i_uncache      (i_uncache),
        .i_cookie       (i_cookie),
        .i_flush        (i_flush),
        .i_cacop_en     (i_cacop_en),
        .i_cacop_code   (i_cacop_code),
        .i_ibar         (i_ibar),
        .o_rready       (o_rready),
        .o_rdata        (o_rdata),
        .o_pc           (o_pc),
        .o_cookie       (o_cookie),
        .o_exc          (o_exc),
        .o_badv         (o_badv),
        .o_idle         (o_idle),
        .o_cacop_ready  (o_cacop_ready),
        .o_cacop_done   (o_cacop_done),
        .o_rd_index     (rd_index),
        .o_wr_index     (wr_index),
        .o_data_we      (data_we),
        .o_tag_we       (tag_we),
        .o_tag_wdata    (tag_wdata),
        .o_tag_inval    (tag_inval),
        .i_tag0         (tag0),
        .i_valid0       (valid0),
        .i_tag1         (tag1),
        .i_valid1       (valid1),
        .i_data0        (data0),
        .i_data1        (data1),
        .o_miss_start   (miss_start),
        .o_miss_addr    (miss_addr),
        .o_miss_uncache (miss_uncache),
        .i_line_done    (line_done),
        .i_fill_line    (fill_line)
    );

    // way 0
    icache_data_ram u_data0 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (data_we[0]),
        .i_wdata    (fill_line),
        .o_rdata    (data0)
    );

    icache_tagv_ram u_tagv0 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (tag_we[0]),
        .i_wtag     (tag_wdata),
        .i_inval    (tag_inval),
        .i_clr_all  (i_ibar),
        .o_tag      (tag0),
        .o_valid    (valid0)
    );

    // way 1
    icache_data_ram u_data1 (
        .clk        (clk),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (data_we[1]),
        .i_wdata    (fill_line),
        .o_rdata    (data1)
    );

    icache_tagv_ram u_tagv1 (
        .clk        (clk),
        .rstn       (rstn),
        .i_rd_index (rd_index),
        .i_wr_index (wr_index),
        .i_we       (tag_we[1]),
        .i_wtag     (tag_wdata),
        .i_inval    (tag_inval),
        .i_clr_all  (i_ibar),
        .o_tag      (tag1),
        .o_valid    (valid1)
    );

    icache_refill u_refill (
        .clk            (clk),
        .rstn           (rstn),
        .i_miss_start   (miss_start),
        .i_miss_addr    (miss_addr),
        .i_miss_uncache (miss_uncache),
        .i_mem_gnt      (i_mem_gnt),
        .i_mem_valid    (i_mem_valid),
        .i_mem_data     (i_mem_data),
        .i_mem_last     (i_mem_last),
        .o_mem_req      (o_mem_req),
        .o_mem_addr     (o_mem_addr),
        .o_mem_beats    (o_mem_beats),
        .o_line_done    (line_done),
        .o_fill_line    (fill_line)
    );

endmodule

`default_nettype wire

//--- tests/tb_icache.sv
`default_nettype none

module tb_icache;

    timeunit 1ns;
    timeprecision 1ps;

    import icache_pkg::*;

    localparam int NUM_STEPS = 40;     // fetches and cacops over all tests
    localparam int MAX_LAT   = 24;     // worst miss latency in cycles

    logic    clk;
    logic    rstn;
    logic    i_rvalid;
    addr_t   i_raddr;
    logic    i_uncache;
    cookie_t i_cookie;
    logic    i_flush;
    logic    i_cacop_en;
    cacop_t  i_cacop_code;
    logic    i_ibar;
    logic    i_mem_gnt;
    logic    i_mem_valid;
    beat_t   i_mem_data;
    logic    i_mem_last;
    logic    o_rready;
    fetch_t  o_rdata;
    addr_t   o_pc;
    cookie_t o_cookie;
    logic    o_exc;
    addr_t   o_badv;
    logic    o_idle;
    logic    o_cacop_ready;
    logic    o_cacop_done;
    logic    o_mem_req;
    addr_t   o_mem_addr;
    logic [2:0] o_mem_beats;

    // expected response of the request in flight
    addr_t   exp_pc;
    cookie_t exp_cookie;
    logic    exp_unc;
    logic    exp_exc;
    logic    pending;
    cookie_t cookie_next;
    int      mem_reqs;
    int      errors;
    int      tests;
    int      test_err0;
    string   test_name;
    logic [31:0] lfsr;

    icache_top i_dut (.*);

    always #10 clk = ~clk;

    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // taps 32 22 2 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            v = (v << 1) | int'(lfsr_step());
        end
        return v;
    endfunction

    // memory image: word = byte address ^ 5a5a0000
    function automatic logic [31:0] mem_word(input addr_t a);
        return a ^ 32'h5a5a_0000;
    endfunction

    function automatic fetch_t fetch_word(input addr_t a);
        addr_t a8;
        a8 = {a[31:3], 3'b000};
        return {mem_word(a8 + 32'd4), mem_word(a8)};
    endfunction

    // memory model, one transfer per request
    initial begin
        addr_t base;
        int    beats;
        forever begin
            @(negedge clk);
            if (rstn && o_mem_req) begin
                base  = o_mem_addr;
                beats = int'(o_mem_beats);
                repeat (rand_bits(2)) @(negedge clk);
                i_mem_gnt = 1'b1;
                @(negedge clk);
                i_mem_gnt = 1'b0;
                mem_reqs++;
                for (int k = 0; k < beats; k++) begin
                    repeat (rand_bits(1)) @(negedge clk);   // sparse beats
                    for (int j = 0; j < 4; j++) begin
                        i_mem_data[j*32 +: 32] = mem_word(base + 32'(16 * k + 4 * j));
                    end
                    i_mem_valid = 1'b1;
                    i_mem_last  = (k == beats - 1);
                    @(negedge clk);
                    i_mem_valid = 1'b0;
                    i_mem_last  = 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rstn && o_rready) begin
            pending = 1'b0;     // response consumed
        end
    end

    a_resp_expected: assert property (@(posedge clk) disable iff (!rstn) o_rready |-> pending)
        else begin
            errors++;
            $display("%s: response without an outstanding request, pc %h",
                test_name, $sampled(o_pc));
        end

    a_resp_pc: assert property (@(posedge clk) disable iff (!rstn)
        o_rready |-> o_pc == exp_pc)
        else begin
            errors++;
            $display("MISMATCH %s pc expected %h actual %h", test_name, exp_pc, $sampled(o_pc));
        end

    a_resp_cookie: assert property (@(posedge clk) disable iff (!rstn)
        o_rready |-> o_cookie == exp_cookie)
        else begin
            errors++;
            $display("MISMATCH %s cookie expected %h actual %h",
                test_name, exp_cookie, $sampled(o_cookie));
        end

    a_resp_data: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready && !exp_exc) |-> (!o_exc && o_rdata == fetch_word(exp_pc)))
        else begin
            errors++;
            $display("MISMATCH %s rdata expected %h actual %h exc %b",
                test_name, fetch_word(exp_pc), $sampled(o_rdata), $sampled(o_exc));
        end

    a_resp_exc: assert property (@(posedge clk) disable iff (!rstn)
        (o_rready && exp_exc) |-> (o_exc && o_badv == exp_pc))
        else begin
            errors++;
            $display("MISMATCH %s badv expected %h actual %h exc %b",
                test_name, exp_pc, $sampled(o_badv), $sampled(o_exc));
        end

    // cached miss is line aligned with 4 beats, uncached is one 8-byte beat
    a_mem_req: assert property (@(posedge clk) disable iff (!rstn)
        o_mem_req |-> (exp_unc ? (o_mem_beats == 3'd1 && o_mem_addr[2:0] == 3'd0)
                               : (o_mem_beats == 3'd4 && o_mem_addr[5:0] == 6'd0)))
        else begin
            errors++;
            $display("MISMATCH %s memory request expected %0d beats actual %0d at %h",
                test_name, exp_unc ? 1 : 4, $sampled(o_mem_beats), $sampled(o_mem_addr));
        end

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s done, %0d errors", test_name, errors - test_err0);
    endtask

    // drive one request and wait for its take edge
    task automatic issue(input addr_t a, input logic unc);
        logic took;
        @(negedge clk);
        cookie_next = cookie_next + 8'd1;
        i_rvalid    = 1'b1;
        i_raddr     = a;
        i_uncache   = unc;
        i_cookie    = cookie_next;
        exp_pc      = a;
        exp_cookie  = cookie_next;
        exp_unc     = unc;
        exp_exc     = a[1:0] != 2'b00;
        pending     = 1'b1;
        took        = 1'b0;
        while (!took) begin
            #1;
            took = o_idle || o_rready;
            @(posedge clk);
            if (!took) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        i_rvalid = 1'b0;
    endtask

    task automatic fetch(input addr_t a, input logic unc, input logic exp_hit,
                         input int exp_reqs);
        int reqs0;
        int cycles;
        reqs0 = mem_reqs;
        issue(a, unc);
        if (exp_hit) begin
            assert (o_rready) else begin
                errors++;
                $display("%s: pc %h not answered one cycle after take", test_name, a);
            end
        end
        cycles = 0;
        while (!o_rready && cycles < MAX_LAT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_rready) begin
            errors++;
            pending = 1'b0;
            $display("%s: no response for pc %h within %0d cycles", test_name, a, MAX_LAT);
        end
        @(posedge clk);
        #1;
        assert (mem_reqs - reqs0 == exp_reqs) else begin
            errors++;
            $display("MISMATCH %s memory requests for %h expected %0d actual %0d",
                test_name, a, exp_reqs, mem_reqs - reqs0);
        end
    endtask

    task automatic cacop(input cacop_t code, input addr_t a);
        logic took;
        @(negedge clk);
        i_cacop_en   = 1'b1;
        i_cacop_code = code;
        i_raddr      = a;
        took         = 1'b0;
        while (!took) begin
            #1;
            took = o_cacop_ready;
            @(posedge clk);
            if (!took) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        i_cacop_en = 1'b0;
        assert (o_cacop_done) else begin
            errors++;
            $display("%s: cacop done missing one cycle after take", test_name);
        end
    endtask

    task automatic ibar();
        @(negedge clk);
        i_ibar = 1'b1;
        @(negedge clk);
        i_ibar = 1'b0;
    endtask

    task automatic flush_during_miss(input addr_t a);
        int cycles;
        issue(a, 1'b0);
        cycles = 0;
        while (!o_mem_req && cycles < MAX_LAT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_mem_req) begin
            errors++;
            $display("%s: no memory request for pc %h before the flush", test_name, a);
        end
        i_flush = 1'b1;
        pending = 1'b0;     // any response now is stray
        @(negedge clk);
        i_flush = 1'b0;
        cycles  = 0;
        while (!o_idle && cycles < MAX_LAT) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_idle) begin
            errors++;
            $display("%s: cache stuck after flush", test_name);
        end
    endtask

    initial begin
        clk = 1'b0;
        rstn = 1'b0;
        i_rvalid = 1'b0;
        i_raddr = '0;
        i_uncache = 1'b0;
        i_cookie = '0;
        i_flush = 1'b0;
        i_cacop_en = 1'b0;
        i_cacop_code = CACOP_IDX0;
        i_ibar = 1'b0;
        i_mem_gnt = 1'b0;
        i_mem_valid = 1'b0;
        i_mem_data = '0;
        i_mem_last = 1'b0;
        exp_pc = '0;
        exp_cookie = '0;
        exp_unc = 1'b0;
        exp_exc = 1'b0;
        pending = 1'b0;
        cookie_next = 8'h40;
        mem_reqs = 0;
        errors = 0;
        tests = 0;
        test_err0 = 0;
        test_name = "reset";
        lfsr = 32'hadd3_ba29;
        repeat (10) @(negedge clk);
        rstn = 1'b1;

        start_test("miss_hit");
        fetch(32'h0000_1040, 1'b0, 1'b0, 1);
        fetch(32'h0000_1048, 1'b0, 1'b1, 0);
        fetch(32'h0000_1078, 1'b0, 1'b1, 0);
        fetch(32'h0000_1040, 1'b0, 1'b1, 0);
        end_test();

        start_test("lru");
        fetch(32'h0000_2080, 1'b0, 1'b0, 1);   // A
        fetch(32'h0000_3080, 1'b0, 1'b0, 1);   // B
        fetch(32'h0000_2088, 1'b0, 1'b1, 0);   // touch A
        fetch(32'h0000_4080, 1'b0, 1'b0, 1);   // C evicts B
        fetch(32'h0000_2080, 1'b0, 1'b1, 0);
        fetch(32'h0000_3080, 1'b0, 1'b0, 1);
        end_test();

        start_test("uncached");
        fetch(32'h0000_510c, 1'b1, 1'b0, 1);
        fetch(32'h0000_510c, 1'b1, 1'b0, 1);
        fetch(32'h0000_5108, 1'b0, 1'b0, 1);
        end_test();

        start_test("misaligned");
        fetch(32'h0000_6002, 1'b0, 1'b1, 0);
        fetch(32'h0000_6013, 1'b0, 1'b1, 0);
        end_test();

        start_test("invalidate");
        cacop(CACOP_HIT, 32'h0000_1040);
        fetch(32'h0000_1050, 1'b0, 1'b0, 1);
        fetch(32'h0000_7140, 1'b0, 1'b0, 1);
        cacop(CACOP_IDX1, 32'h0000_7141);       // way 1
        fetch(32'h0000_7140, 1'b0, 1'b1, 0);    // still in way 0
        cacop(CACOP_IDX0, 32'h0000_7140);       // way 0
        fetch(32'h0000_7140, 1'b0, 1'b0, 1);
        fetch(32'h0000_1040, 1'b0, 1'b1, 0);
        fetch(32'h0000_2080, 1'b0, 1'b1, 0);
        ibar();
        fetch(32'h0000_1040, 1'b0, 1'b0, 1);
        fetch(32'h0000_2080, 1'b0, 1'b0, 1);
        fetch(32'h0000_7140, 1'b0, 1'b0, 1);
        end_test();

        start_test("flush");
        flush_during_miss(32'h0000_8200);
        fetch(32'h0000_9248, 1'b0, 1'b0, 1);
        end_test();

        repeat (4) @(negedge clk);
        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog sized from the step count and the worst miss
    initial begin
        #((10 + NUM_STEPS * MAX_LAT) * 20);
        $display("watchdog expired, the run did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- icache.f
rtl/icache_pkg.sv
rtl/icache_data_ram.sv
rtl/icache_tagv_ram.sv
rtl/icache_refill.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tests/tb_icache.sv

//--- run.sh
#!/bin/sh
# Build and run the icache testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_icache \
    -f icache.f \
    -o sim_icache
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_icache > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
